// File: include/rob_params.svh
// reorder buffer parameters
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

`define ROB_ELEMENTS      15    // usable entries
`define ROB_SLOTS         16    // one slot stays free, full vs empty
`define ROB_TAG_W         4     // log2 of slots, pointers wrap on their own
`define ROB_PAYLOAD_W     10
`define ROB_ALLOC_LANES   4
`define ROB_CMPL_LANES    3
`define ROB_RETIRE_LANES  4
`define ROB_LANE_CT_W     3     // holds 0..4
`define ROB_OCC_W         5     // holds 0..15 with headroom
`define ROB_WB_ADR_W      2
`define ROB_WB_DAT_W      16

`endif

// File: src/rob_types_pkg.sv
// reorder buffer data types
`default_nettype none
`include "rob_params.svh"

package rob_types_pkg;

    // slot index, also the tag handed to dispatch
    typedef logic [`ROB_TAG_W-1:0]     rob_tag_t;

    typedef logic [`ROB_PAYLOAD_W-1:0] rob_payload_t;  // entry data

    typedef logic [`ROB_LANE_CT_W-1:0] rob_lane_ct_t;  // alloc / retire lane count

    typedef logic [`ROB_OCC_W-1:0]     rob_occ_t;      // live entries

endpackage

`default_nettype wire

// File: src/rob_csr_pkg.sv
// register map of the reorder buffer
`default_nettype none
`include "rob_params.svh"

package rob_csr_pkg;

    // word addresses on the wishbone port
    typedef enum logic [`ROB_WB_ADR_W-1:0] {
        REG_CTRL    = 2'd0,  // retire enable, flush
        REG_STATUS  = 2'd1,  // occupancy, read only
        REG_RETIRED = 2'd2   // retired entry count, read only
    } rob_reg_e;

    localparam int CTRL_RETIRE_EN_BIT = 0;
    localparam int CTRL_FLUSH_BIT     = 1;  // self clearing

endpackage

`default_nettype wire

// File: src/rob_buffer.sv
// reorder buffer entry store
`timescale 1ns/1ns
`default_nettype none
`include "rob_params.svh"

module rob_buffer import rob_types_pkg::*; (
    input  wire               clk,
    input  wire               rst,

    input  wire               flush,
    input  wire               retire_en,

    // dispatch side, low lanes filled first
    input  wire rob_lane_ct_t alloc_ct,
    input  wire rob_payload_t alloc_data [`ROB_ALLOC_LANES],
    output rob_lane_ct_t      alloc_ready_ct,
    output rob_tag_t          alloc_tags [`ROB_ALLOC_LANES],

    // execution units mark entries done by tag
    input  wire [`ROB_CMPL_LANES-1:0] cmpl_valid,
    input  wire rob_tag_t     cmpl_tags [`ROB_CMPL_LANES],

    // in-order retire
    output rob_lane_ct_t      retire_valid_ct,
    output rob_payload_t      retire_data [`ROB_RETIRE_LANES],
    input  wire rob_lane_ct_t retire_ready_ct,

    output rob_lane_ct_t      retire_ct,
    output rob_occ_t          occupancy
);

    localparam int ALLOC_N  = `ROB_ALLOC_LANES;
    localparam int CMPL_N   = `ROB_CMPL_LANES;
    localparam int RETIRE_N = `ROB_RETIRE_LANES;

    rob_tag_t              rd_ptr;   // oldest live entry
    rob_tag_t              wr_ptr;   // next slot to allocate

    rob_payload_t          mem [`ROB_SLOTS];
    logic [`ROB_SLOTS-1:0] done;     // one per slot, cleared on allocate

    rob_occ_t              free_ct;
    rob_lane_ct_t          run_ct;   // done run at the head, capped
    rob_tag_t              rd_slot [RETIRE_N];

    // pointer difference taken mod 16 before widening
    assign occupancy = rob_occ_t'(rob_tag_t'(wr_ptr - rd_ptr));
    assign free_ct   = rob_occ_t'(`ROB_ELEMENTS) - occupancy;

    assign alloc_ready_ct = (free_ct >= rob_occ_t'(ALLOC_N)) ? rob_lane_ct_t'(ALLOC_N)
                                                             : rob_lane_ct_t'(free_ct);

    // tags the next allocations will receive
    always_comb begin
        for (int i = 0; i < ALLOC_N; i++) begin
            alloc_tags[i] = wr_ptr + rob_tag_t'(i);
        end
    end

    // head window and length of the completed run
    always_comb begin
        run_ct = '0;
        for (int i = 0; i < RETIRE_N; i++) begin
            rd_slot[i]     = rd_ptr + rob_tag_t'(i);
            retire_data[i] = mem[rd_slot[i]];
            // only extends while every older lane was done
            if (run_ct == rob_lane_ct_t'(i) && rob_occ_t'(i) < occupancy &&
                done[rd_slot[i]]) begin
                run_ct = run_ct + 1'b1;
            end
        end
    end

    assign retire_valid_ct = retire_en ? run_ct : '0;

    // a flush discards this cycle's retirement
    always_comb begin
        if (flush) begin
            retire_ct = '0;
        end else if (retire_ready_ct < retire_valid_ct) begin
            retire_ct = retire_ready_ct;  // consumer back-pressure
        end else begin
            retire_ct = retire_valid_ct;
        end
    end

    // pointers and done bits
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            done   <= '0;
        end else begin
            for (int i = 0; i < ALLOC_N; i++) begin
                if (rob_lane_ct_t'(i) < alloc_ct) begin
                    done[alloc_tags[i]] <= 1'b0;
                end
            end
            // completions come after, a tag is never both
            for (int i = 0; i < CMPL_N; i++) begin
                if (cmpl_valid[i]) begin
                    done[cmpl_tags[i]] <= 1'b1;
                end
            end
            wr_ptr <= wr_ptr + rob_tag_t'(alloc_ct);
            rd_ptr <= rd_ptr + rob_tag_t'(retire_ct);
        end
    end

    // payload store
    always_ff @(posedge clk) begin
        for (int i = 0; i < ALLOC_N; i++) begin
            if (!flush && rob_lane_ct_t'(i) < alloc_ct) begin
                mem[alloc_tags[i]] <= alloc_data[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rob_csr.sv
// reorder buffer control registers
`timescale 1ns/1ns
`default_nettype none
`include "rob_params.svh"

module rob_csr import rob_types_pkg::*, rob_csr_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,

    // wishbone classic slave
    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    input  wire                       wb_we,
    input  wire rob_reg_e             wb_adr,
    input  wire [`ROB_WB_DAT_W-1:0]   wb_wdata,
    output logic [`ROB_WB_DAT_W-1:0]  wb_rdata,
    output logic                      wb_ack,

    input  wire rob_occ_t             occupancy,
    input  wire rob_lane_ct_t         retire_ct,

    output logic                      retire_en,
    output logic                      flush
);

    localparam int DAT_W = `ROB_WB_DAT_W;

    logic             wb_req;       // request seen, ack not yet given
    logic             ctrl_wr;
    logic [DAT_W-1:0] retired_cnt;
    logic [DAT_W-1:0] rd_mux;

    assign wb_req  = wb_cyc && wb_stb && !wb_ack;
    assign ctrl_wr = wb_req && wb_we && (wb_adr == REG_CTRL);

    // ack, control register and flush pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            retire_en <= 1'b1;
            flush     <= 1'b0;
        end else begin
            wb_ack <= wb_req;  // single cycle, master drops stb after it
            flush  <= ctrl_wr && wb_wdata[CTRL_FLUSH_BIT];
            if (ctrl_wr) begin
                retire_en <= wb_wdata[CTRL_RETIRE_EN_BIT];
            end
        end
    end

    // wrapping count of retired entries
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            retired_cnt <= '0;
        end else begin
            retired_cnt <= retired_cnt + DAT_W'(retire_ct);
        end
    end

    always_comb begin
        rd_mux = '0;
        case (wb_adr)
            REG_CTRL:    rd_mux[CTRL_RETIRE_EN_BIT] = retire_en;  // flush reads 0
            REG_STATUS:  rd_mux = DAT_W'(occupancy);
            REG_RETIRED: rd_mux = retired_cnt;
            default:     rd_mux = '0;
        endcase
    end

    // captured with the request so it is stable while ack is high
    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: src/rob_top.sv
// reorder buffer subsystem top
`timescale 1ns/1ns
`default_nettype none
`include "rob_params.svh"

module rob_top import rob_types_pkg::*, rob_csr_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,

    input  wire rob_lane_ct_t         alloc_ct,
    input  wire rob_payload_t         alloc_data [`ROB_ALLOC_LANES],
    output rob_lane_ct_t              alloc_ready_ct,
    output rob_tag_t                  alloc_tags [`ROB_ALLOC_LANES],

    input  wire [`ROB_CMPL_LANES-1:0] cmpl_valid,
    input  wire rob_tag_t             cmpl_tags [`ROB_CMPL_LANES],

    output rob_lane_ct_t              retire_valid_ct,
    output rob_payload_t              retire_data [`ROB_RETIRE_LANES],
    input  wire rob_lane_ct_t         retire_ready_ct,

    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    input  wire                       wb_we,
    input  wire rob_reg_e             wb_adr,
    input  wire [`ROB_WB_DAT_W-1:0]   wb_wdata,
    output logic [`ROB_WB_DAT_W-1:0]  wb_rdata,
    output logic                      wb_ack
);

    logic         retire_en;
    logic         flush;      // one cycle, from a CTRL write
    rob_occ_t     occupancy;
    rob_lane_ct_t retire_ct;  // entries actually removed

    rob_buffer u_buffer (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .retire_en       (retire_en),
        .alloc_ct        (alloc_ct),
        .alloc_data      (alloc_data),
        .alloc_ready_ct  (alloc_ready_ct),
        .alloc_tags      (alloc_tags),
        .cmpl_valid      (cmpl_valid),
        .cmpl_tags       (cmpl_tags),
        .retire_valid_ct (retire_valid_ct),
        .retire_data     (retire_data),
        .retire_ready_ct (retire_ready_ct),
        .retire_ct       (retire_ct),
        .occupancy       (occupancy)
    );

    rob_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .occupancy (occupancy),
        .retire_ct (retire_ct),
        .retire_en (retire_en),
        .flush     (flush)
    );

endmodule

`default_nettype wire

// File: tb/rob_sva.sv
// reorder buffer assertions
`timescale 1ns/1ns
`default_nettype none
`include "rob_params.svh"

module rob_sva import rob_types_pkg::*; (
    input wire               clk,
    input wire               rst,
    input wire               flush,
    input wire               retire_en,
    input wire rob_occ_t     occupancy,
    input wire rob_lane_ct_t retire_ct,
    input wire rob_lane_ct_t retire_valid_ct,
    input wire rob_lane_ct_t alloc_ct,
    input wire rob_lane_ct_t alloc_ready_ct
);

    // live count moves by what was allocated and retired, no wrap past 15
    occ_tracks_counts: assert property (@(posedge clk) disable iff (rst)
        !flush |=> occupancy == $past(occupancy) + $past(alloc_ct) - $past(retire_ct))
        else $error("occupancy does not follow allocations and retirements");

    // entries the consumer left behind are still done at the head
    rest_stays_at_head: assert property (@(posedge clk) disable iff (rst)
        !flush && retire_ct < retire_valid_ct |=>
            !retire_en || retire_valid_ct >= $past(retire_valid_ct) - $past(retire_ct))
        else $error("entries left at the head lost their done state");

    alloc_within_ready: assert property (@(posedge clk) disable iff (rst)
        alloc_ct <= alloc_ready_ct)
        else $error("dispatch allocated past the free count");

    // buffer is empty the cycle after a flush
    empty_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> occupancy == '0)
        else $error("buffer not empty after flush");

endmodule

bind rob_buffer rob_sva u_sva (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .retire_en       (retire_en),
    .occupancy       (occupancy),
    .retire_ct       (retire_ct),
    .retire_valid_ct (retire_valid_ct),
    .alloc_ct        (alloc_ct),
    .alloc_ready_ct  (alloc_ready_ct)
);

`default_nettype wire

// File: tb/rob_tb.sv
// reorder buffer testbench
`timescale 1ns/1ns
`default_nettype none
`include "rob_params.svh"

module rob_tb import rob_types_pkg::*, rob_csr_pkg::*; ();

    localparam int MAX_CYCLES = 4000;  // the tests need about 600 cycles

    typedef struct packed {
        rob_tag_t     tag;
        rob_payload_t payload;
        logic         done;
    } entry_t;

    logic                       clk = 1'b0;
    logic                       rst;
    rob_lane_ct_t               alloc_ct;
    rob_payload_t               alloc_data [`ROB_ALLOC_LANES];
    rob_lane_ct_t               alloc_ready_ct;
    rob_tag_t                   alloc_tags [`ROB_ALLOC_LANES];
    logic [`ROB_CMPL_LANES-1:0] cmpl_valid;
    rob_tag_t                   cmpl_tags [`ROB_CMPL_LANES];
    rob_lane_ct_t               retire_valid_ct;
    rob_payload_t               retire_data [`ROB_RETIRE_LANES];
    rob_lane_ct_t               retire_ready_ct;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    rob_reg_e                   wb_adr;
    logic [`ROB_WB_DAT_W-1:0]   wb_wdata;
    logic [`ROB_WB_DAT_W-1:0]   wb_rdata;
    logic                       wb_ack;

    // scoreboard state
    entry_t      model_q [$];
    rob_tag_t    wr_tag;
    logic [15:0] model_retired;
    logic        model_en;
    logic        flush_next;     // flush lands on the next rising edge

    int          error_ct = 0;
    int          test_ct = 0;
    int          failed_ct = 0;
    int          err_base = 0;
    int          cycle_ct = 0;
    int          ready;
    int          pick;
    int          cand [$];
    rob_tag_t    tg [3];
    logic [2:0]  cv;

    rob_top dut (.*);

    always #10 clk = ~clk;

    function automatic int expected_valid_ct(input entry_t model [$], input logic en);
        int n;
        n = 0;
        if (!en) begin
            return 0;
        end
        while (n < `ROB_RETIRE_LANES && n < model.size() && model[n].done) begin
            n++;
        end
        return n;
    endfunction

    task automatic log_mismatch(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        error_ct++;
    endtask

    task automatic end_test(input string name);
        test_ct++;
        if (error_ct == err_base) begin
            $display("test %0d %s: ok", test_ct, name);
        end else begin
            $display("test %0d %s: %0d errors", test_ct, name, error_ct - err_base);
            failed_ct++;
        end
        err_base = error_ct;
    endtask

    task automatic apply_inputs(input int a_ct, input int r_ct, input logic [2:0] valid,
                                input rob_tag_t t0, input rob_tag_t t1, input rob_tag_t t2);
        alloc_ct = rob_lane_ct_t'(a_ct);
        for (int i = 0; i < `ROB_ALLOC_LANES; i++) begin
            alloc_data[i] = rob_payload_t'($urandom);
        end
        cmpl_valid      = valid;
        cmpl_tags[0]    = t0;
        cmpl_tags[1]    = t1;
        cmpl_tags[2]    = t2;
        retire_ready_ct = rob_lane_ct_t'(r_ct);
    endtask

    task automatic drive_cycle(input int a_ct, input int r_ct, input logic [2:0] valid,
                               input rob_tag_t t0, input rob_tag_t t1, input rob_tag_t t2);
        @(negedge clk);
        apply_inputs(a_ct, r_ct, valid, t0, t1, t2);
    endtask

    // keeps taking entries until the head run is empty
    task automatic retire_all_done();
        drive_cycle(0, 4, 3'b000, 0, 0, 0);
        while (retire_valid_ct != 0) begin
            drive_cycle(0, 4, 3'b000, 0, 0, 0);
        end
    endtask

    task automatic wb_write(input rob_reg_e adr, input logic [15:0] data);
        @(negedge clk);
        alloc_ct   = '0;
        cmpl_valid = '0;
        wb_cyc     = 1'b1;
        wb_stb     = 1'b1;
        wb_we      = 1'b1;
        wb_adr     = adr;
        wb_wdata   = data;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        if (adr == REG_CTRL) begin
            model_en   = data[CTRL_RETIRE_EN_BIT];
            flush_next = data[CTRL_FLUSH_BIT];
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input rob_reg_e adr);
        logic [15:0] exp;
        @(negedge clk);
        alloc_ct   = '0;
        cmpl_valid = '0;
        case (adr)
            REG_STATUS:  exp = 16'(model_q.size());
            REG_RETIRED: exp = model_retired;
            default:     exp = {15'd0, model_en};
        endcase
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        assert (wb_rdata == exp)
            else log_mismatch($sformatf("read %s got %0d, expected %0d",
                                        adr.name(), wb_rdata, exp));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // compare against the model and advance it with this edge's inputs
    always @(posedge clk) begin : scoreboard
        int     exp_v;
        int     exp_ready;
        int     n_ret;
        entry_t e;
        if (rst || flush_next) begin
            model_q.delete();
            wr_tag        = '0;
            model_retired = '0;
            flush_next    = 1'b0;
            if (rst) model_en = 1'b1;
        end else begin
            exp_v     = expected_valid_ct(model_q, model_en);
            exp_ready = `ROB_ELEMENTS - model_q.size();
            if (exp_ready > `ROB_ALLOC_LANES) exp_ready = `ROB_ALLOC_LANES;
            assert (retire_valid_ct == exp_v)
                else log_mismatch($sformatf("retire_valid_ct %0d, expected %0d",
                                            retire_valid_ct, exp_v));
            assert (alloc_ready_ct == exp_ready)
                else log_mismatch($sformatf("alloc_ready_ct %0d, expected %0d",
                                            alloc_ready_ct, exp_ready));
            for (int i = 0; i < `ROB_ALLOC_LANES; i++) begin
                assert (alloc_tags[i] == rob_tag_t'(wr_tag + i))
                    else log_mismatch($sformatf("alloc_tags[%0d] is %0d", i, alloc_tags[i]));
            end
            for (int i = 0; i < `ROB_RETIRE_LANES && i < model_q.size(); i++) begin
                assert (retire_data[i] == model_q[i].payload)
                    else log_mismatch($sformatf("retire_data[%0d] %h, expected %h",
                                                i, retire_data[i], model_q[i].payload));
            end
            n_ret = (retire_ready_ct < exp_v) ? int'(retire_ready_ct) : exp_v;
            repeat (n_ret) void'(model_q.pop_front());
            model_retired = model_retired + 16'(n_ret);
            for (int l = 0; l < `ROB_CMPL_LANES; l++) begin
                foreach (model_q[j]) begin
                    if (cmpl_valid[l] && model_q[j].tag == cmpl_tags[l]) model_q[j].done = 1'b1;
                end
            end
            for (int i = 0; i < alloc_ct; i++) begin
                e.tag     = wr_tag;
                e.payload = alloc_data[i];
                e.done    = 1'b0;
                model_q.push_back(e);
                wr_tag    = wr_tag + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_ct++;
        if (cycle_ct >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(42341));  // one seed for the whole run
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = REG_CTRL;
        wb_wdata = '0;
        apply_inputs(0, 0, 3'b000, 0, 0, 0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // 4 + 4 + 4 + 3 fills all 15 entries
        drive_cycle(4, 4, 3'b000, 0, 0, 0);
        drive_cycle(4, 4, 3'b000, 0, 0, 0);
        drive_cycle(4, 4, 3'b000, 0, 0, 0);
        drive_cycle(3, 4, 3'b000, 0, 0, 0);
        drive_cycle(0, 4, 3'b000, 0, 0, 0);
        assert (alloc_ready_ct == 0) else log_mismatch("alloc_ready_ct not 0 when full");
        end_test("fill");

        drive_cycle(0, 4, 3'b111, 3, 2, 1);
        drive_cycle(0, 4, 3'b111, 5, 4, 6);
        drive_cycle(0, 4, 3'b001, 0, 0, 0);  // oldest done so run 0..6 goes
        retire_all_done();
        end_test("out of order completion");

        drive_cycle(0, 0, 3'b111, 7, 8, 9);
        drive_cycle(0, 0, 3'b111, 10, 11, 12);
        drive_cycle(0, 2, 3'b000, 0, 0, 0);
        assert (retire_valid_ct == 4) else log_mismatch("retire_valid_ct not 4");
        drive_cycle(0, 1, 3'b000, 0, 0, 0);
        drive_cycle(0, 0, 3'b000, 0, 0, 0);
        assert (retire_valid_ct == 3) else log_mismatch("retire_valid_ct not 3 after partial");
        end_test("partial retire");

        wb_write(REG_CTRL, 16'h0000);
        drive_cycle(0, 4, 3'b000, 0, 0, 0);
        assert (retire_valid_ct == 0) else log_mismatch("retire_valid_ct not 0 while disabled");
        wb_read(REG_STATUS);
        wb_read(REG_RETIRED);
        wb_write(REG_CTRL, 16'h0001);
        retire_all_done();
        wb_read(REG_RETIRED);
        end_test("retire enable");

        wb_write(REG_CTRL, 16'h0003);
        wb_read(REG_RETIRED);
        wb_read(REG_STATUS);
        drive_cycle(0, 4, 3'b000, 0, 0, 0);
        assert (alloc_ready_ct == 4) else log_mismatch("alloc_ready_ct not 4 after flush");
        end_test("flush");

        for (int c = 0; c < 500; c++) begin
            @(negedge clk);
            cand.delete();
            foreach (model_q[j]) begin
                if (!model_q[j].done) cand.push_back(model_q[j].tag);
            end
            ready = `ROB_ELEMENTS - model_q.size();
            if (ready > `ROB_ALLOC_LANES) ready = `ROB_ALLOC_LANES;
            cv = '0;
            for (int l = 0; l < 3; l++) begin
                tg[l] = '0;
                if (cand.size() > 0 && $urandom_range(1, 0) == 1) begin
                    pick  = $urandom_range(cand.size() - 1, 0);
                    tg[l] = rob_tag_t'(cand[pick]);
                    cv[l] = 1'b1;
                    cand.delete(pick);
                end
            end
            apply_inputs($urandom_range(ready, 0), $urandom_range(4, 0), cv, tg[0], tg[1], tg[2]);
        end
        drive_cycle(0, 0, 3'b000, 0, 0, 0);
        wb_read(REG_STATUS);
        wb_read(REG_RETIRED);
        end_test("random traffic");

        $display("%0d tests run, %0d failed, %0d mismatches", test_ct, failed_ct, error_ct);
        if (error_ct == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
src/rob_types_pkg.sv
src/rob_csr_pkg.sv
src/rob_buffer.sv
src/rob_csr.sv
src/rob_top.sv
tb/rob_sva.sv
tb/rob_tb.sv
